/* compile.f */
source/soc_io_pkg.sv
source/io_bus_ctrl.sv
source/dsp_mult_unit.sv
source/ym_ctrl.sv
source/soc_io_top.sv
test/soc_io_tb.sv

/* source/dsp_mult_unit.sv */
// Signed 16x16 multiplier
// Two write-only operand registers, product registered every cycle

module dsp_mult_unit
    import soc_io_pkg::*;
(
    input  logic        cpu_clk,
    input  periph_wr_t  wr,
    output logic [31:0] product
);

    logic signed [15:0] op_a;
    logic signed [15:0] op_b;

    // Flat enables so the operands map onto the DSP input registers
    always_ff @(posedge cpu_clk) begin
        if (wr.dsp_a_we) begin
            op_a <= wr.data[15:0];
        end

        if (wr.dsp_b_we) begin
            op_b <= wr.data[15:0];
        end

        product <= op_a * op_b;
    end

    // Decoder picks one operand per write
    a_one_operand: assert property (
        @(posedge cpu_clk)
        wr.dsp_a_we |-> !wr.dsp_b_we
    );

endmodule

/* source/io_bus_ctrl.sv */
// Bus handshake FSM with fixed two-cycle latency
// Address decode into peripheral write strobes
// Gamepad control register and read data select

module io_bus_ctrl
    import soc_io_pkg::*;
(
    input  logic         cpu_clk,
    input  logic         cpu_reset,

    input  cpu_bus_req_t req,
    output cpu_bus_rsp_t rsp,

    output periph_wr_t   wr,

    input  logic [31:0]  product,
    input  logic         ym_busy,

    input  logic [1:0]   pad_data,
    input  logic         user_button,
    output logic         pad_latch,
    output logic         pad_clk
);

    bus_state_t  state;
    io_region_t  region;
    logic        accept;
    logic [31:0] rd_mux;
    logic [31:0] rdata_q;
    logic [1:0]  pad_ctrl;

    assign region = io_region_t'(req.addr[REGION_MSB:REGION_LSB]);
    assign accept = (state == BUS_IDLE) && req.valid;

    // Handshake FSM
    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            state <= BUS_IDLE;
        end else begin
            case (state)
                BUS_IDLE: begin
                    if (req.valid) begin
                        state <= BUS_WAIT;
                    end
                end
                BUS_WAIT: state <= BUS_DONE;
                BUS_DONE: state <= BUS_IDLE;
                default:  state <= BUS_IDLE;
            endcase
        end
    end

    // Strobes fire in the cycle after the accepting edge
    always_ff @(posedge cpu_clk) begin
        wr.data  <= req.wdata;
        wr.ym_a0 <= req.addr[AUDIO_A0_BIT];

        if (cpu_reset) begin
            wr.dsp_a_we <= 1'b0;
            wr.dsp_b_we <= 1'b0;
            wr.ym_we    <= 1'b0;
            wr.presc_we <= 1'b0;
        end else begin
            wr.dsp_a_we <= 1'b0;
            wr.dsp_b_we <= 1'b0;
            wr.ym_we    <= 1'b0;
            wr.presc_we <= 1'b0;

            if (accept && req.write) begin
                case (region)
                    REGION_DSP: begin
                        wr.dsp_b_we <= req.addr[DSP_SEL_BIT];
                        wr.dsp_a_we <= !req.addr[DSP_SEL_BIT];
                    end
                    REGION_AUDIO: begin
                        wr.presc_we <= req.addr[AUDIO_PRESC_BIT];
                        wr.ym_we    <= !req.addr[AUDIO_PRESC_BIT];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // Gamepad control, bit 0 latch and bit 1 clock
    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            pad_ctrl <= 2'b00;
        end else if (accept && req.write && region == REGION_PAD) begin
            pad_ctrl <= req.wdata[1:0];
        end
    end

    assign pad_latch = pad_ctrl[0];
    assign pad_clk   = pad_ctrl[1];

    // Read source by region, unmapped reads as zero
    always_comb begin
        rd_mux = '0;
        case (region)
            REGION_DSP:   rd_mux = product;
            REGION_AUDIO: rd_mux[YM_BUSY_BIT] = ym_busy;
            REGION_PAD:   rd_mux = {29'b0, user_button, pad_data};
            default:      rd_mux = '0;
        endcase
    end

    // Captured on the way into BUS_DONE
    always_ff @(posedge cpu_clk) begin
        if (state == BUS_WAIT) begin
            rdata_q <= rd_mux;
        end
    end

    assign rsp.ready = (state == BUS_DONE);
    assign rsp.rdata = rdata_q;

    // One-cycle ready, whatever the requester does with valid
    a_ready_single: assert property (
        @(posedge cpu_clk) disable iff (cpu_reset)
        rsp.ready |=> !rsp.ready
    );

    a_no_strobe_idle: assert property (
        @(posedge cpu_clk) disable iff (cpu_reset)
        (state == BUS_IDLE) |-> !(wr.dsp_a_we || wr.dsp_b_we || wr.ym_we || wr.presc_we)
    );

endmodule

/* source/soc_io_pkg.sv */
// Shared types for the CPU peripheral bus slice
// Bus request and response, peripheral write strobes, YM2151 write port
// Region and handshake enums, address map bit positions

package soc_io_pkg;

    // CPU side of the bus, held steady by the requester until ready
    typedef struct packed {
        logic        valid;
        logic        write;
        logic [15:0] addr;
        logic [31:0] wdata;
    } cpu_bus_req_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } cpu_bus_rsp_t;

    // Decoded single-cycle write strobes with their payload
    typedef struct packed {
        logic        dsp_a_we;
        logic        dsp_b_we;
        logic        ym_we;
        logic        presc_we;
        logic        ym_a0;
        logic [31:0] data;
    } periph_wr_t;

    // External YM2151 write port
    typedef struct packed {
        logic       write_en;
        logic       a0;
        logic [7:0] data;
    } ym_port_t;

    // Region field sits in addr[7:4]
    localparam int unsigned REGION_MSB = 7;
    localparam int unsigned REGION_LSB = 4;

    typedef enum logic [3:0] {
        REGION_DSP   = 4'd0,
        REGION_AUDIO = 4'd1,
        REGION_PAD   = 4'd2
    } io_region_t;

    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_WAIT,
        BUS_DONE
    } bus_state_t;

    // Bit positions within a region
    localparam int unsigned DSP_SEL_BIT     = 2;
    localparam int unsigned AUDIO_PRESC_BIT = 3;
    localparam int unsigned AUDIO_A0_BIT    = 2;

    // Busy flag position in audio read data
    localparam int unsigned YM_BUSY_BIT = 7;

endpackage

/* source/soc_io_top.sv */
// Peripheral slice top level
// Bus controller, multiplier and YM2151 control side by side

module soc_io_top
    import soc_io_pkg::*;
#(
    parameter int PRESC_WIDTH = 32
) (
    input  logic         cpu_clk,
    input  logic         cpu_reset,

    input  cpu_bus_req_t req,
    output cpu_bus_rsp_t rsp,

    // YM2151 chip side
    input  logic         ym_busy,
    output ym_port_t     ym_port,
    output logic         ym_cen,
    output logic         ym_cen_p1,

    // Gamepad port
    input  logic [1:0]   pad_data,
    input  logic         user_button,
    output logic         pad_latch,
    output logic         pad_clk
);

    periph_wr_t  wr;
    logic [31:0] product;

    io_bus_ctrl io_bus_ctrl_i (
        .cpu_clk     (cpu_clk),
        .cpu_reset   (cpu_reset),
        .req         (req),
        .rsp         (rsp),
        .wr          (wr),
        .product     (product),
        .ym_busy     (ym_busy),
        .pad_data    (pad_data),
        .user_button (user_button),
        .pad_latch   (pad_latch),
        .pad_clk     (pad_clk)
    );

    dsp_mult_unit dsp_mult_unit_i (
        .cpu_clk (cpu_clk),
        .wr      (wr),
        .product (product)
    );

    ym_ctrl #(
        .PRESC_WIDTH (PRESC_WIDTH)
    ) ym_ctrl_i (
        .cpu_clk   (cpu_clk),
        .cpu_reset (cpu_reset),
        .wr        (wr),
        .ym_port   (ym_port),
        .ym_cen    (ym_cen),
        .ym_cen_p1 (ym_cen_p1)
    );

endmodule

/* source/ym_ctrl.sv */
// YM2151 control front end
// Pending chip write and single-cycle write pulse
// Fractional prescaler with full-rate and half-rate clock enables

module ym_ctrl
    import soc_io_pkg::*;
#(
    parameter int PRESC_WIDTH = 32
) (
    input  logic       cpu_clk,
    input  logic       cpu_reset,

    input  periph_wr_t wr,

    output ym_port_t   ym_port,
    output logic       ym_cen,
    output logic       ym_cen_p1
);

    logic [PRESC_WIDTH-1:0] presc_inc;
    logic [PRESC_WIDTH:0]   presc_acc;
    logic                   presc_tick;
    logic                   p1_toggle;

    // Pending write, pulse follows one cycle after the strobe
    always_ff @(posedge cpu_clk) begin
        if (wr.ym_we) begin
            ym_port.a0   <= wr.ym_a0;
            ym_port.data <= wr.data[7:0];
        end

        if (cpu_reset) begin
            ym_port.write_en <= 1'b0;
        end else begin
            ym_port.write_en <= wr.ym_we;
        end
    end

    // Increment set by software, zero holds the enables off
    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            presc_inc <= '0;
        end else if (wr.presc_we) begin
            presc_inc <= wr.data[PRESC_WIDTH-1:0];
        end
    end

    // Top accumulator bit is the overflow, cleared as it is consumed
    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            presc_acc  <= '0;
            presc_tick <= 1'b0;
        end else begin
            presc_tick <= 1'b0;
            presc_acc  <= presc_acc + {1'b0, presc_inc};

            if (presc_acc[PRESC_WIDTH]) begin
                presc_tick             <= 1'b1;
                presc_acc[PRESC_WIDTH] <= 1'b0;
            end
        end
    end

    // Full-rate enable on every tick, half rate on every second
    always_ff @(posedge cpu_clk) begin
        if (cpu_reset) begin
            ym_cen    <= 1'b0;
            ym_cen_p1 <= 1'b0;
            p1_toggle <= 1'b0;
        end else begin
            ym_cen    <= 1'b0;
            ym_cen_p1 <= 1'b0;

            if (presc_tick) begin
                ym_cen    <= 1'b1;
                ym_cen_p1 <= p1_toggle;
                p1_toggle <= !p1_toggle;
            end
        end
    end

    // Relies on single-cycle strobes from the bus side
    a_write_pulse: assert property (
        @(posedge cpu_clk) disable iff (cpu_reset)
        ym_port.write_en |=> !ym_port.write_en
    );

    a_p1_with_cen: assert property (
        @(posedge cpu_clk) disable iff (cpu_reset)
        ym_cen_p1 |-> ym_cen
    );

endmodule

/* test/bus_patterns.txt */
// kind addr data expect aux, all numbers in hex
// W and R are bus accesses, aux drives ym_busy, R data drives pad inputs on pad reads
// C counts clock enables over data cycles, expect is ym_cen and aux is ym_cen_p1
C 0000 00000064 00000000 00000000
W 0000 DEAD0003 00000000 00000000
W 0004 00000005 00000000 00000000
R 0000 00000000 0000000F 00000000
W 0000 0000FFFE 00000000 00000000
W 0004 00000007 00000000 00000000
R 0000 00000000 FFFFFFF2 00000000
W 0000 00008000 00000000 00000000
W 0004 00008000 00000000 00000000
R 0000 00000000 40000000 00000000
W 0000 00007FFF 00000000 00000000
R 0000 00000000 C0008000 00000000
W 0000 0000FFFF 00000000 00000000
W 0004 0000FFFF 00000000 00000000
R 0000 00000000 00000001 00000000
W 0000 00001234 00000000 00000000
W 0004 0000FF00 00000000 00000000
R 0000 00000000 FFEDCC00 00000000
W 0010 000000A5 00000000 00000000
W 0014 0000013C 00000000 00000000
R 0010 00000000 00000080 00000001
R 0010 00000000 00000000 00000000
W 0018 40000000 00000000 00000000
C 0000 00000064 00000019 0000000C
W 0018 80000000 00000000 00000000
C 0000 00000028 00000014 0000000A
W 0020 00000001 00000000 00000000
W 0020 00000002 00000000 00000000
R 0020 00000005 00000005 00000000
R 0020 00000002 00000002 00000000
R 0030 00000000 00000000 00000000
W 00F0 12345678 00000000 00000000
R 0070 00000000 00000000 00000000

/* test/soc_io_tb.sv */
// Testbench for the peripheral slice top level
// Reads bus patterns, plays the CPU side of the handshake, checks read data
// Counts YM2151 write pulses and clock enables, closing report

module soc_io_tb
    import soc_io_pkg::*;
();

    localparam int    CLK_PERIOD     = 20;
    localparam int    DRIVE_DELAY    = 2;
    localparam int    RESET_CYCLES   = 3;
    localparam int    READY_LIMIT    = 8;
    localparam int    BUS_LINE_COST  = 4;
    localparam int    TIMEOUT_MARGIN = 40;
    localparam string PATTERN_FILE   = "test/bus_patterns.txt";

    // Region codes in addr[7:4] and the prescaler select bit
    localparam logic [3:0] AUDIO_REGION = 4'h1;
    localparam logic [3:0] PAD_REGION   = 4'h2;
    localparam int         PRESC_SEL    = 3;

    logic         cpu_clk;
    logic         cpu_reset;
    cpu_bus_req_t req;
    cpu_bus_rsp_t rsp;
    logic         ym_busy;
    ym_port_t     ym_port;
    logic         ym_cen;
    logic         ym_cen_p1;
    logic [1:0]   pad_data;
    logic         user_button;
    logic         pad_latch;
    logic         pad_clk;

    // Pattern lines, one entry per line of the file
    byte         kind_q[$];
    logic [15:0] addr_q[$];
    logic [31:0] data_q[$];
    logic [31:0] exp_q[$];
    logic [31:0] aux_q[$];

    int         error_count = 0;
    int         check_count = 0;
    int         cycle_count = 0;
    int         cycle_limit = 0;
    bit         patterns_loaded;
    int         cen_count = 0;
    int         p1_count = 0;
    int         write_pulses = 0;
    logic       last_a0;
    logic [7:0] last_ym_data;

    soc_io_top #(
        .PRESC_WIDTH (32)
    ) soc_io_top_i (
        .cpu_clk     (cpu_clk),
        .cpu_reset   (cpu_reset),
        .req         (req),
        .rsp         (rsp),
        .ym_busy     (ym_busy),
        .ym_port     (ym_port),
        .ym_cen      (ym_cen),
        .ym_cen_p1   (ym_cen_p1),
        .pad_data    (pad_data),
        .user_button (user_button),
        .pad_latch   (pad_latch),
        .pad_clk     (pad_clk)
    );

    initial begin
        cpu_clk = 1'b0;
        forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
    end

    // Mid-cycle sampling of the chip side outputs
    always @(negedge cpu_clk) begin
        if (ym_cen === 1'b1) begin
            cen_count++;
        end
        if (ym_cen_p1 === 1'b1) begin
            p1_count++;
        end
        if (ym_port.write_en === 1'b1) begin
            write_pulses++;
            last_a0      = ym_port.a0;
            last_ym_data = ym_port.data;
        end
    end

    always @(posedge cpu_clk) begin
        cycle_count++;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles, the pattern run did not finish", cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] got);
        check_count++;
        assert (got === expected) else begin
            $display("FAILED %s expected %h got %h", name, expected, got);
            error_count++;
        end
    endtask

    // Zero must be exact, anything else may be off by one
    task automatic compare_count(input string name, input int expected, input int got);
        int diff;
        diff = got - expected;
        check_count++;
        assert ((expected == 0) ? (got == 0) : (diff >= -1 && diff <= 1)) else begin
            $display("FAILED %s expected %h got %h", name, expected, got);
            error_count++;
        end
    endtask

    task automatic confirm(input bit cond, input string what);
        check_count++;
        assert (cond) else begin
            $display("%s", what);
            error_count++;
        end
    endtask

    task automatic load_patterns();
        int          fd;
        int          code;
        int          ch;
        int          bus_lines;
        int          enable_cycles;
        byte         kind;
        logic [15:0] addr;
        logic [31:0] data;
        logic [31:0] exp_val;
        logic [31:0] aux;
        bus_lines = 0;
        enable_cycles = 0;
        fd = $fopen(PATTERN_FILE, "r");
        patterns_loaded = (fd != 0);
        if (fd != 0) begin
            code = $fscanf(fd, " %c", kind);
            while (code == 1) begin
                if (kind == "/") begin
                    // Comment line, skip to its end
                    ch = $fgetc(fd);
                    while (ch != "\n" && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else begin
                    code = $fscanf(fd, "%h %h %h %h", addr, data, exp_val, aux);
                    kind_q.push_back(kind);
                    addr_q.push_back(addr);
                    data_q.push_back(data);
                    exp_q.push_back(exp_val);
                    aux_q.push_back(aux);
                    if (kind == "C") begin
                        enable_cycles += data;
                    end else begin
                        bus_lines++;
                    end
                end
                code = $fscanf(fd, " %c", kind);
            end
            $fclose(fd);
            cycle_limit = RESET_CYCLES + bus_lines * BUS_LINE_COST + enable_cycles
                          + TIMEOUT_MARGIN;
        end
    endtask

    // One bus access, four cycles from raising valid to the next free slot
    task automatic bus_transfer(input byte kind, input logic [15:0] addr,
                                input logic [31:0] data, input logic [31:0] exp_data,
                                input logic busy);
        int         waited;
        int         pulses_before;
        logic       is_write;
        logic [3:0] region;
        is_write = (kind == "W");
        region = addr[7:4];
        pulses_before = write_pulses;
        ym_busy = busy;
        if (!is_write && region == PAD_REGION) begin
            pad_data    = data[1:0];
            user_button = data[2];
        end
        req.valid = 1'b1;
        req.write = is_write;
        req.addr  = addr;
        req.wdata = is_write ? data : 32'h0;
        waited = 0;
        do begin
            @(posedge cpu_clk);
            #DRIVE_DELAY;
            waited++;
        end while (!rsp.ready && waited < READY_LIMIT);
        confirm(rsp.ready, $sformatf("ready never rose for the access at address %h", addr));
        if (rsp.ready) begin
            compare_value("ready latency", 32'd2, waited);
            if (!is_write) begin
                compare_value("rdata", exp_data, rsp.rdata);
            end
        end
        @(posedge cpu_clk);
        #DRIVE_DELAY;
        confirm(!rsp.ready, "ready stayed high for more than one cycle");
        req.valid = 1'b0;
        @(posedge cpu_clk);
        #DRIVE_DELAY;
        // Side effects of the access
        if (is_write && region == AUDIO_REGION && !addr[PRESC_SEL]) begin
            compare_value("write_en pulses", pulses_before + 1, write_pulses);
            compare_value("ym_port.a0", addr[2], last_a0);
            compare_value("ym_port.data", data[7:0], last_ym_data);
        end else begin
            confirm(write_pulses == pulses_before, "chip write pulse without a chip write");
        end
        if (is_write && region == PAD_REGION) begin
            compare_value("pad_latch", data[0], pad_latch);
            compare_value("pad_clk", data[1], pad_clk);
        end
    endtask

    task automatic count_enables(input int cycles, input int exp_cen, input int exp_p1);
        int cen_start;
        int p1_start;
        cen_start = cen_count;
        p1_start = p1_count;
        repeat (cycles) @(posedge cpu_clk);
        #DRIVE_DELAY;
        compare_count("ym_cen count", exp_cen, cen_count - cen_start);
        compare_count("ym_cen_p1 count", exp_p1, p1_count - p1_start);
    endtask

    initial begin
        cpu_reset   = 1'b1;
        req         = '0;
        ym_busy     = 1'b0;
        pad_data    = 2'b00;
        user_button = 1'b0;
        load_patterns();
        if (!patterns_loaded) begin
            $display("Could not open the pattern file %s", PATTERN_FILE);
            $display("ERRORS FOUND");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge cpu_clk);
            #DRIVE_DELAY;
            cpu_reset = 1'b0;
            for (int i = 0; i < kind_q.size(); i++) begin
                case (kind_q[i])
                    "W", "R": bus_transfer(kind_q[i], addr_q[i], data_q[i], exp_q[i],
                                           aux_q[i][0]);
                    "C":      count_enables(data_q[i], exp_q[i], aux_q[i]);
                    default:  confirm(1'b0, $sformatf("Unknown pattern kind on entry %0d", i));
                endcase
            end
            $display("%0d checks, %0d errors", check_count, error_count);
            if (error_count == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

endmodule
